/* source/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data and address widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// Machine-mode CSR addresses
`define CSR_A_MSTATUS       12'h300
`define CSR_A_MISA          12'h301
`define CSR_A_MIE           12'h304
`define CSR_A_MTVEC         12'h305
`define CSR_A_MSCRATCH      12'h340
`define CSR_A_MEPC          12'h341
`define CSR_A_MCAUSE        12'h342
`define CSR_A_MIP           12'h344

// MXL = 1, extensions I and M
`define CSR_MISA_VALUE      32'h4000_1100

// Field positions in mstatus, mie and mip
`define CSR_MSTATUS_MIE     3
`define CSR_MSTATUS_MPIE    7
`define CSR_MSTATUS_MPP     11
`define CSR_IRQ_MSI_BIT     3
`define CSR_IRQ_MTI_BIT     7
`define CSR_IRQ_MEI_BIT     11

`define CSR_MTVEC_VECTORED  2'b01

// Cause codes with ecall adding the current mode to the base
`define CSR_CAUSE_ECALL_U   32'd8
`define CSR_CAUSE_MSI       32'h8000_0003
`define CSR_CAUSE_MTI       32'h8000_0007
`define CSR_CAUSE_MEI       32'h8000_000b

`endif

/* source/csr_pkg.sv */
`include "csr_cfg.svh"

package csr_pkg;

    // Plain data word and CSR address
    typedef logic [`CSR_XLEN-1:0]   xlen_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Cause word with bit 31 marking an interrupt
    typedef logic [`CSR_XLEN-1:0]   cause_t;

    // Only U and M modes exist
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        M_MODE = 2'd3
    } priv_mode_t;

    // Commands carried by a request
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_t;

    // Interrupt lines with bit 0 software, bit 1 timer and bit 2 external
    typedef logic [2:0]             irq_vec_t;

endpackage

/* source/csr_decode_stage.sv */
`include "csr_cfg.svh"

module csr_decode_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  csr_pkg::csr_cmd_t   cmd_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      wdata_i,
    input  csr_pkg::xlen_t      pc_i,
    input  logic                exc_valid_i,
    input  csr_pkg::cause_t     exc_cause_i,
    output logic                d_valid_o,
    output csr_pkg::csr_cmd_t   d_cmd_o,
    output csr_pkg::csr_addr_t  d_addr_o,
    output csr_pkg::xlen_t      d_wdata_o,
    output csr_pkg::xlen_t      d_pc_o,
    output logic                d_exc_valid_o,
    output csr_pkg::cause_t     d_exc_cause_o,
    output logic                d_is_write_o,
    output logic                d_addr_ro_o
);

    import csr_pkg::*;

    logic is_write;
    logic addr_ro;

    // Mode-independent checks done one cycle ahead of execute
    assign is_write = (cmd_i == CMD_W) || (cmd_i == CMD_S) || (cmd_i == CMD_C);

    // Top two address bits 11 mean read only
    assign addr_ro = (addr_i[`CSR_ADDR_W-1 -: 2] == 2'b11);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            d_valid_o <= 1'b0;
        end else begin
            d_valid_o <= req_valid_i;
        end
    end

    // Payload only moves with a request
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            d_cmd_o       <= cmd_i;
            d_addr_o      <= addr_i;
            d_wdata_o     <= wdata_i;
            d_pc_o        <= pc_i;
            d_exc_valid_o <= exc_valid_i;
            d_exc_cause_o <= exc_cause_i;
            d_is_write_o  <= is_write;
            d_addr_ro_o   <= addr_ro;
        end
    end

endmodule

/* source/csr_trap_ctrl.sv */
`include "csr_cfg.svh"

module csr_trap_ctrl (
    input  csr_pkg::priv_mode_t mode_i,
    input  logic                mstatus_mie_i,
    input  csr_pkg::irq_vec_t   mie_i,
    input  csr_pkg::irq_vec_t   mip_i,
    input  csr_pkg::xlen_t      mtvec_i,
    input  logic                exc_valid_i,
    input  csr_pkg::cause_t     exc_cause_i,
    input  logic                is_ecall_i,
    output logic                irq_take_o,
    output csr_pkg::cause_t     trap_cause_o,
    output csr_pkg::xlen_t      trap_vector_o
);

    import csr_pkg::*;

    irq_vec_t pending;
    logic     global_en;
    logic     exc_present;
    cause_t   irq_cause;
    xlen_t    vec_base;

    // U-mode interrupts are always globally enabled
    assign global_en  = (mode_i == M_MODE) ? mstatus_mie_i : 1'b1;
    assign pending    = mie_i & mip_i;
    assign irq_take_o = global_en & (|pending);

    // Fixed priority MEI, MSI, MTI
    always_comb begin
        if (pending[2]) begin
            irq_cause = `CSR_CAUSE_MEI;
        end else if (pending[0]) begin
            irq_cause = `CSR_CAUSE_MSI;
        end else begin
            irq_cause = `CSR_CAUSE_MTI;
        end
    end

    assign exc_present = exc_valid_i | is_ecall_i;

    // Exception beats interrupt
    always_comb begin
        if (is_ecall_i) begin
            trap_cause_o = `CSR_CAUSE_ECALL_U + {30'b0, mode_i};
        end else if (exc_valid_i) begin
            trap_cause_o = exc_cause_i;
        end else begin
            trap_cause_o = irq_cause;
        end
    end

    assign vec_base = {mtvec_i[`CSR_XLEN-1:2], 2'b00};

    // Vectored mode only offsets interrupts
    always_comb begin
        if ((mtvec_i[1:0] == `CSR_MTVEC_VECTORED) && !exc_present) begin
            trap_vector_o = vec_base + {irq_cause[`CSR_XLEN-3:0], 2'b00};
        end else begin
            trap_vector_o = vec_base;
        end
    end

endmodule

/* source/csr_regfile.sv */
`include "csr_cfg.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                d_valid_i,
    input  csr_pkg::csr_cmd_t   d_cmd_i,
    input  csr_pkg::csr_addr_t  d_addr_i,
    input  csr_pkg::xlen_t      d_wdata_i,
    input  csr_pkg::xlen_t      d_pc_i,
    input  logic                d_exc_valid_i,
    input  logic                d_is_write_i,
    input  logic                d_addr_ro_i,
    input  csr_pkg::irq_vec_t   irq_i,
    input  logic                irq_take_i,
    input  csr_pkg::cause_t     trap_cause_i,
    input  csr_pkg::xlen_t      trap_vector_i,
    output logic                is_ecall_o,
    output csr_pkg::priv_mode_t mode_o,
    output logic                mstatus_mie_o,
    output csr_pkg::irq_vec_t   mie_o,
    output csr_pkg::irq_vec_t   mip_o,
    output csr_pkg::xlen_t      mtvec_o,
    output logic                rdata_valid_o,
    output csr_pkg::xlen_t      rdata_o,
    output logic                redirect_o,
    output csr_pkg::xlen_t      redirect_pc_o
);

    import csr_pkg::*;

    priv_mode_t mode_q;
    priv_mode_t mpp_q;
    logic       mie_q;
    logic       mpie_q;
    irq_vec_t   irq_en_q;
    xlen_t      mtvec_q;
    xlen_t      mscratch_q;
    xlen_t      mepc_q;
    cause_t     mcause_q;

    logic       is_mret;
    logic       take_trap;
    logic       can_access;
    logic       can_write;
    xlen_t      status_word;
    xlen_t      enable_word;
    xlen_t      pending_word;
    xlen_t      csr_value;
    xlen_t      new_value;

    assign is_ecall_o = (d_cmd_i == CMD_ECALL);
    assign is_mret    = (d_cmd_i == CMD_MRET);
    assign take_trap  = d_valid_i & (d_exc_valid_i | is_ecall_o | irq_take_i);

    // Privilege level encoded in address bits 9:8
    assign can_access = (d_addr_i[`CSR_ADDR_W-3 -: 2] <= mode_q);
    assign can_write  = can_access & d_is_write_i & ~d_addr_ro_i;

    assign mode_o        = mode_q;
    assign mstatus_mie_o = mie_q;
    assign mie_o         = irq_en_q;
    assign mip_o         = irq_i;
    assign mtvec_o       = mtvec_q;

    // Assemble the sparse register views
    always_comb begin
        status_word = '0;
        status_word[`CSR_MSTATUS_MIE]      = mie_q;
        status_word[`CSR_MSTATUS_MPIE]     = mpie_q;
        status_word[`CSR_MSTATUS_MPP +: 2] = mpp_q;
        enable_word = '0;
        enable_word[`CSR_IRQ_MSI_BIT] = irq_en_q[0];
        enable_word[`CSR_IRQ_MTI_BIT] = irq_en_q[1];
        enable_word[`CSR_IRQ_MEI_BIT] = irq_en_q[2];
        pending_word = '0;
        pending_word[`CSR_IRQ_MSI_BIT] = irq_i[0];
        pending_word[`CSR_IRQ_MTI_BIT] = irq_i[1];
        pending_word[`CSR_IRQ_MEI_BIT] = irq_i[2];
    end

    always_comb begin
        case (d_addr_i)
            `CSR_A_MSTATUS:  csr_value = status_word;
            `CSR_A_MISA:     csr_value = `CSR_MISA_VALUE;
            `CSR_A_MIE:      csr_value = enable_word;
            `CSR_A_MTVEC:    csr_value = mtvec_q;
            `CSR_A_MSCRATCH: csr_value = mscratch_q;
            `CSR_A_MEPC:     csr_value = mepc_q;
            `CSR_A_MCAUSE:   csr_value = mcause_q;
            `CSR_A_MIP:      csr_value = pending_word;
            default:         csr_value = '0;
        endcase
    end

    // Read-modify-write operand
    always_comb begin
        case (d_cmd_i)
            CMD_S:   new_value = csr_value | d_wdata_i;
            CMD_C:   new_value = csr_value & ~d_wdata_i;
            default: new_value = d_wdata_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mode_q        <= M_MODE;
            mpp_q         <= M_MODE;
            mie_q         <= 1'b0;
            mpie_q        <= 1'b0;
            irq_en_q      <= '0;
            mtvec_q       <= '0;
            mscratch_q    <= '0;
            mepc_q        <= '0;
            mcause_q      <= '0;
            rdata_valid_o <= 1'b0;
            redirect_o    <= 1'b0;
        end else begin
            rdata_valid_o <= d_valid_i & d_is_write_i & ~take_trap;
            redirect_o    <= take_trap | (d_valid_i & is_mret);
            if (take_trap) begin
                mcause_q <= trap_cause_i;
                mepc_q   <= d_pc_i;
                mpie_q   <= mie_q;
                mie_q    <= 1'b0;
                mpp_q    <= mode_q;
                mode_q   <= M_MODE;
            end else if (d_valid_i && is_mret) begin
                mie_q  <= mpie_q;
                mpie_q <= 1'b1;
                mode_q <= mpp_q;
                mpp_q  <= U_MODE;
            end else if (d_valid_i && can_write) begin
                case (d_addr_i)
                    `CSR_A_MSTATUS: begin
                        mie_q  <= new_value[`CSR_MSTATUS_MIE];
                        mpie_q <= new_value[`CSR_MSTATUS_MPIE];
                        // MPP holds only legal modes
                        mpp_q  <= (new_value[`CSR_MSTATUS_MPP +: 2] == 2'b11) ? M_MODE : U_MODE;
                    end
                    `CSR_A_MIE: begin
                        irq_en_q <= {new_value[`CSR_IRQ_MEI_BIT],
                                     new_value[`CSR_IRQ_MTI_BIT],
                                     new_value[`CSR_IRQ_MSI_BIT]};
                    end
                    // Mode field is direct or vectored only
                    `CSR_A_MTVEC:    mtvec_q    <= {new_value[`CSR_XLEN-1:2], 1'b0, new_value[0]};
                    `CSR_A_MSCRATCH: mscratch_q <= new_value;
                    `CSR_A_MEPC:     mepc_q     <= {new_value[`CSR_XLEN-1:2], 2'b00};
                    `CSR_A_MCAUSE:   mcause_q   <= new_value;
                    default: begin
                    end
                endcase
            end
        end
    end

    // Old value or zero when access is refused
    always_ff @(posedge clk) begin
        if (d_valid_i) begin
            rdata_o       <= can_access ? csr_value : '0;
            redirect_pc_o <= take_trap ? trap_vector_i : mepc_q;
        end
    end

endmodule

/* source/csr_unit.sv */
`include "csr_cfg.svh"

module csr_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  csr_pkg::csr_cmd_t   cmd_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      wdata_i,
    input  csr_pkg::xlen_t      pc_i,
    input  logic                exc_valid_i,
    input  csr_pkg::cause_t     exc_cause_i,
    input  csr_pkg::irq_vec_t   irq_i,
    output logic                rdata_valid_o,
    output csr_pkg::xlen_t      rdata_o,
    output logic                redirect_o,
    output csr_pkg::xlen_t      redirect_pc_o,
    output csr_pkg::priv_mode_t mode_o
);

    import csr_pkg::*;

    // Decode to execute
    logic       d_valid;
    csr_cmd_t   d_cmd;
    csr_addr_t  d_addr;
    xlen_t      d_wdata;
    xlen_t      d_pc;
    logic       d_exc_valid;
    cause_t     d_exc_cause;
    logic       d_is_write;
    logic       d_addr_ro;

    // Regfile state seen by the trap logic
    logic       is_ecall;
    logic       mstatus_mie;
    irq_vec_t   mie_bits;
    irq_vec_t   mip_bits;
    xlen_t      mtvec;

    // Trap decision back into execute
    logic       irq_take;
    cause_t     trap_cause;
    xlen_t      trap_vector;

    csr_decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .cmd_i         (cmd_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .pc_i          (pc_i),
        .exc_valid_i   (exc_valid_i),
        .exc_cause_i   (exc_cause_i),
        .d_valid_o     (d_valid),
        .d_cmd_o       (d_cmd),
        .d_addr_o      (d_addr),
        .d_wdata_o     (d_wdata),
        .d_pc_o        (d_pc),
        .d_exc_valid_o (d_exc_valid),
        .d_exc_cause_o (d_exc_cause),
        .d_is_write_o  (d_is_write),
        .d_addr_ro_o   (d_addr_ro)
    );

    csr_trap_ctrl u_trap_ctrl (
        .mode_i        (mode_o),
        .mstatus_mie_i (mstatus_mie),
        .mie_i         (mie_bits),
        .mip_i         (mip_bits),
        .mtvec_i       (mtvec),
        .exc_valid_i   (d_exc_valid),
        .exc_cause_i   (d_exc_cause),
        .is_ecall_i    (is_ecall),
        .irq_take_o    (irq_take),
        .trap_cause_o  (trap_cause),
        .trap_vector_o (trap_vector)
    );

    csr_regfile u_regfile (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .d_valid_i     (d_valid),
        .d_cmd_i       (d_cmd),
        .d_addr_i      (d_addr),
        .d_wdata_i     (d_wdata),
        .d_pc_i        (d_pc),
        .d_exc_valid_i (d_exc_valid),
        .d_is_write_i  (d_is_write),
        .d_addr_ro_i   (d_addr_ro),
        .irq_i         (irq_i),
        .irq_take_i    (irq_take),
        .trap_cause_i  (trap_cause),
        .trap_vector_i (trap_vector),
        .is_ecall_o    (is_ecall),
        .mode_o        (mode_o),
        .mstatus_mie_o (mstatus_mie),
        .mie_o         (mie_bits),
        .mip_o         (mip_bits),
        .mtvec_o       (mtvec),
        .rdata_valid_o (rdata_valid_o),
        .rdata_o       (rdata_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* tests/csr_unit_tb.sv */
`include "csr_cfg.svh"

module csr_unit_tb;

    import csr_pkg::*;

    logic        clk;
    logic        rst_n_i;
    logic        req_valid_i;
    csr_cmd_t    cmd_i;
    csr_addr_t   addr_i;
    xlen_t       wdata_i;
    xlen_t       pc_i;
    logic        exc_valid_i;
    cause_t      exc_cause_i;
    irq_vec_t    irq_i;
    logic        rdata_valid_o;
    xlen_t       rdata_o;
    logic        redirect_o;
    xlen_t       redirect_pc_o;
    priv_mode_t  mode_o;

    // Stimulus columns
    string       row_name[$];
    csr_cmd_t    row_cmd[$];
    csr_addr_t   row_addr[$];
    xlen_t       row_wdata[$];
    xlen_t       row_pc[$];
    logic        row_exc[$];
    cause_t      row_cause[$];
    irq_vec_t    row_irq[$];

    // Expected columns
    logic        exp_rvalid[$];
    xlen_t       exp_rdata[$];
    logic        exp_redirect[$];
    xlen_t       exp_rpc[$];
    priv_mode_t  exp_mode[$];

    irq_vec_t    irq_level;
    int          cycle_count;
    int          cycle_limit;
    int unsigned seed_value;

    csr_unit UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .cmd_i         (cmd_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .pc_i          (pc_i),
        .exc_valid_i   (exc_valid_i),
        .exc_cause_i   (exc_cause_i),
        .irq_i         (irq_i),
        .rdata_valid_o (rdata_valid_o),
        .rdata_o       (rdata_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .mode_o        (mode_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_xlen(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_mode(input string name, input priv_mode_t expected,
                              input priv_mode_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // A CSR command that completes with a read pulse
    task automatic add_access(input string name, input csr_cmd_t cmd, input csr_addr_t addr,
                              input xlen_t wdata, input xlen_t rdata, input priv_mode_t mode);
        row_name.push_back(name);
        row_cmd.push_back(cmd);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_pc.push_back('0);
        row_exc.push_back(1'b0);
        row_cause.push_back('0);
        row_irq.push_back(irq_level);
        exp_rvalid.push_back(1'b1);
        exp_rdata.push_back(rdata);
        exp_redirect.push_back(1'b0);
        exp_rpc.push_back('0);
        exp_mode.push_back(mode);
    endtask

    // A request that ends in a trap or MRET with don't-care write data
    task automatic add_redirect(input string name, input csr_cmd_t cmd, input csr_addr_t addr,
                                input xlen_t pc, input logic exc, input cause_t cause,
                                input xlen_t target, input priv_mode_t mode);
        row_name.push_back(name);
        row_cmd.push_back(cmd);
        row_addr.push_back(addr);
        row_wdata.push_back($urandom);
        row_pc.push_back(pc);
        row_exc.push_back(exc);
        row_cause.push_back(cause);
        row_irq.push_back(irq_level);
        exp_rvalid.push_back(1'b0);
        exp_rdata.push_back('0);
        exp_redirect.push_back(1'b1);
        exp_rpc.push_back(target);
        exp_mode.push_back(mode);
    endtask

    task automatic build_table();
        irq_level = 3'b000;
        // Read-modify-write on mscratch
        add_access("rmw_write", CMD_W, `CSR_A_MSCRATCH, 32'h1234_5678, 32'h0, M_MODE);
        add_access("rmw_set", CMD_S, `CSR_A_MSCRATCH, 32'h0000_f00f, 32'h1234_5678, M_MODE);
        add_access("rmw_clear", CMD_C, `CSR_A_MSCRATCH, 32'h1200_000f, 32'h1234_f67f, M_MODE);
        add_access("rmw_read", CMD_S, `CSR_A_MSCRATCH, 32'h0, 32'h0034_f670, M_MODE);
        // misa is fixed
        add_access("misa_write", CMD_W, `CSR_A_MISA, $urandom, 32'h4000_1100, M_MODE);
        add_access("misa_read", CMD_S, `CSR_A_MISA, 32'h0, 32'h4000_1100, M_MODE);
        add_access("mtvec_direct", CMD_W, `CSR_A_MTVEC, 32'h0000_0100, 32'h0, M_MODE);
        // Low two bits of mepc drop
        add_access("mepc_write", CMD_W, `CSR_A_MEPC, 32'h0000_1003, 32'h0, M_MODE);
        add_access("mepc_read", CMD_S, `CSR_A_MEPC, 32'h0, 32'h0000_1000, M_MODE);
        // Set MPIE and move MPP from its reset value M to U
        add_access("mstatus_mpp_u", CMD_W, `CSR_A_MSTATUS, 32'h80, 32'h1800, M_MODE);
        add_redirect("mret_to_u", CMD_MRET, '0, 32'h200, 1'b0, '0, 32'h1000, U_MODE);
        // U-mode sees zero and cannot write
        add_access("u_read_mscratch", CMD_S, `CSR_A_MSCRATCH, 32'h0, 32'h0, U_MODE);
        add_access("u_write_mscratch", CMD_W, `CSR_A_MSCRATCH, $urandom, 32'h0, U_MODE);
        add_redirect("ecall_u", CMD_ECALL, '0, 32'h400, 1'b0, '0, 32'h100, M_MODE);
        add_access("m_read_mscratch", CMD_S, `CSR_A_MSCRATCH, 32'h0, 32'h0034_f670, M_MODE);
        add_access("mcause_ecall_u", CMD_S, `CSR_A_MCAUSE, 32'h0, 32'd8, M_MODE);
        add_access("mepc_ecall_u", CMD_S, `CSR_A_MEPC, 32'h0, 32'h400, M_MODE);
        // MPIE holds the MIE restored by MRET and MPP is U
        add_access("mstatus_ecall_u", CMD_S, `CSR_A_MSTATUS, 32'h0, 32'h80, M_MODE);
        add_redirect("exc_in_m", CMD_NONE, '0, 32'h500, 1'b1, 32'd2, 32'h100, M_MODE);
        add_access("mcause_exc", CMD_S, `CSR_A_MCAUSE, 32'h0, 32'd2, M_MODE);
        add_access("mepc_exc", CMD_S, `CSR_A_MEPC, 32'h0, 32'h500, M_MODE);
        add_access("mstatus_exc", CMD_S, `CSR_A_MSTATUS, 32'h0, 32'h1800, M_MODE);
        add_redirect("ecall_m", CMD_ECALL, '0, 32'h600, 1'b0, '0, 32'h100, M_MODE);
        add_access("mcause_ecall_m", CMD_S, `CSR_A_MCAUSE, 32'h0, 32'd11, M_MODE);
        // Interrupts with vectored mtvec
        add_access("mtvec_vectored", CMD_W, `CSR_A_MTVEC, 32'h0000_0201, 32'h100, M_MODE);
        add_access("mie_enable_all", CMD_W, `CSR_A_MIE, 32'h888, 32'h0, M_MODE);
        irq_level = 3'b110;
        add_access("irq_masked_m", CMD_S, `CSR_A_MSCRATCH, 32'h0, 32'h0034_f670, M_MODE);
        add_access("mip_read", CMD_S, `CSR_A_MIP, 32'h0, 32'h880, M_MODE);
        irq_level = 3'b000;
        add_access("mstatus_set_mie", CMD_S, `CSR_A_MSTATUS, 32'h8, 32'h1800, M_MODE);
        irq_level = 3'b110;
        // MEI wins over MTI and pre-empts the CSR command
        add_redirect("irq_mei", CMD_S, `CSR_A_MSCRATCH, 32'h700, 1'b0, '0,
                     32'h200 + 4 * 32'd11, M_MODE);
        add_access("mcause_mei", CMD_S, `CSR_A_MCAUSE, 32'h0, 32'h8000_000b, M_MODE);
        irq_level = 3'b000;
        add_access("mepc_mei", CMD_S, `CSR_A_MEPC, 32'h0, 32'h700, M_MODE);
        add_access("mstatus_mei", CMD_S, `CSR_A_MSTATUS, 32'h0, 32'h1880, M_MODE);
        add_access("mscratch_kept", CMD_S, `CSR_A_MSCRATCH, 32'h0, 32'h0034_f670, M_MODE);
    endtask

    task automatic check_outputs(input int r);
        check_bit({row_name[r], ".rdata_valid"}, exp_rvalid[r], rdata_valid_o);
        if (exp_rvalid[r]) begin
            check_xlen({row_name[r], ".rdata"}, exp_rdata[r], rdata_o);
        end
        check_bit({row_name[r], ".redirect"}, exp_redirect[r], redirect_o);
        if (exp_redirect[r]) begin
            check_xlen({row_name[r], ".redirect_pc"}, exp_rpc[r], redirect_pc_o);
        end
        check_mode({row_name[r], ".mode"}, exp_mode[r], mode_o);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int c;
        int n_rows;
        seed_value  = $urandom(75186);
        cycle_count = 0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        cmd_i       = CMD_NONE;
        addr_i      = '0;
        wdata_i     = '0;
        pc_i        = '0;
        exc_valid_i = 1'b0;
        exc_cause_i = '0;
        irq_i       = '0;
        build_table();
        n_rows      = row_name.size();
        cycle_limit = n_rows + 8 + 10;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_bit("reset.rdata_valid", 1'b0, rdata_valid_o);
        check_bit("reset.redirect", 1'b0, redirect_o);
        check_mode("reset.mode", M_MODE, mode_o);
        // Row c enters decode as row c-2 leaves execute
        for (c = 0; c < n_rows + 2; c++) begin
            @(posedge clk);
            if (c < n_rows) begin
                req_valid_i <= 1'b1;
                cmd_i       <= row_cmd[c];
                addr_i      <= row_addr[c];
                wdata_i     <= row_wdata[c];
                pc_i        <= row_pc[c];
                exc_valid_i <= row_exc[c];
                exc_cause_i <= row_cause[c];
            end else begin
                req_valid_i <= 1'b0;
                cmd_i       <= CMD_NONE;
                exc_valid_i <= 1'b0;
            end
            // Interrupt levels are sampled in execute one cycle behind the request
            if (c >= 1 && c <= n_rows) begin
                irq_i <= row_irq[c - 1];
            end else begin
                irq_i <= '0;
            end
            @(negedge clk);
            if (c >= 2) begin
                check_outputs(c - 2);
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* project.f */
+incdir+source
source/csr_pkg.sv
source/csr_decode_stage.sv
source/csr_trap_ctrl.sv
source/csr_regfile.sv
source/csr_unit.sv
tests/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module csr_unit_tb -f project.f -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/csr_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
